//--- rtl/exu_consts.svh
/*
 * widths shared by the execute stage packages and RTL
 * data and pc share one width, and the shift amount follows from it
 */
`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

// data path width, also used for the pc
`define EXU_XLEN 64

// register file index width
`define EXU_REG_AW 5

// hard-wired zero register, never forwarded
`define EXU_ZERO_REG 0

`endif

//--- rtl/exu_op_pkg.sv
/*
 * operation encodings from decode
 * multiply, divide and 32-bit word variants are not supported
 */
package exu_op_pkg;

    // integer alu operations
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    // control transfer kind, BR_NONE for plain alu work
    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_BEQ  = 4'd1,
        BR_BNE  = 4'd2,
        BR_BLT  = 4'd3,
        BR_BGE  = 4'd4,
        BR_BLTU = 4'd5,
        BR_BGEU = 4'd6,
        BR_JAL  = 4'd7,
        BR_JALR = 4'd8
    } branch_op_e;

endpackage

//--- rtl/exu_data_pkg.sv
/*
 * data path types of the execute stage
 * widths come from the shared constants header
 */
`include "exu_consts.svh"

package exu_data_pkg;

    // one integer register value
    typedef logic [`EXU_XLEN-1:0] xword_t;

    // program counter, same width as data
    typedef logic [`EXU_XLEN-1:0] pc_t;

    // register file index
    typedef logic [`EXU_REG_AW-1:0] reg_idx_t;

endpackage

//--- rtl/operand_bypass.sv
/*
 * source operand forwarding and load-use detection
 * priority is ex/ls register, then writeback, then the stall capture
 * index 0 never forwards and never stalls
 */
`include "exu_consts.svh"

module operand_bypass
    import exu_data_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ls_flush,
    input  logic     id_valid,
    input  logic     id_accept,
    input  reg_idx_t id_rs1,
    input  reg_idx_t id_rs2,
    input  xword_t   id_operand1,
    input  xword_t   id_operand2,
    input  logic     ex_valid,
    input  logic     ex_dest_wen,
    input  logic     ex_load,
    input  reg_idx_t ex_rd,
    input  xword_t   ex_result,
    input  logic     wb_valid,
    input  logic     wb_dest_wen,
    input  reg_idx_t wb_rd,
    input  xword_t   wb_data,
    output xword_t   src1,
    output xword_t   src2,
    output logic     load_hazard
);

    reg_idx_t   rs_idx [2];
    xword_t     id_opnd [2];
    xword_t     src_sel [2];
    logic [1:0] use_hit;

    // a write to a nonzero index that matches the source
    function automatic logic idx_hit(input reg_idx_t src, input reg_idx_t dst,
                                     input logic wen);
        return wen && (src == dst) && (src != reg_idx_t'(`EXU_ZERO_REG));
    endfunction

    assign rs_idx[0]  = id_rs1;
    assign rs_idx[1]  = id_rs2;
    assign id_opnd[0] = id_operand1;
    assign id_opnd[1] = id_operand2;

    // ********************
    // per source forwarding
    for (genvar i = 0; i < 2; i++) begin : g_src
        logic   ex_hit;
        logic   wb_hit;
        logic   cap_valid;
        xword_t cap_data;

        assign ex_hit = idx_hit(rs_idx[i], ex_rd, ex_valid && ex_dest_wen);
        assign wb_hit = idx_hit(rs_idx[i], wb_rd, wb_valid && wb_dest_wen);

        // a result still sitting in ex/ls as a load address is not the data
        assign use_hit[i] = ex_hit && ex_load;

        // writeback seen while stalled is gone by the time we issue
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                cap_valid <= 1'b0;
            end else if (ls_flush || id_accept) begin
                cap_valid <= 1'b0;
            end else if (id_valid && wb_hit) begin
                cap_valid <= 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (id_valid && !id_accept && wb_hit) begin
                cap_data <= wb_data;
            end
        end

        assign src_sel[i] = ex_hit    ? ex_result :
                            wb_hit    ? wb_data   :
                            cap_valid ? cap_data  :
                                        id_opnd[i];
    end

    assign src1 = src_sel[0];
    assign src2 = src_sel[1];

    // load-use, either source
    assign load_hazard = |use_hit;

endmodule

//--- rtl/int_alu.sv
/*
 * combinational 64-bit integer alu
 * shifts take the low bits of op_b only, no word variants
 */
`include "exu_consts.svh"

module int_alu
    import exu_data_pkg::*;
    import exu_op_pkg::*;
(
    input  alu_op_e alu_op,
    input  xword_t  op_a,
    input  xword_t  op_b,
    output xword_t  result
);

    localparam int SHAMT_W = $clog2(`EXU_XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    assign shamt       = op_b[SHAMT_W-1:0];
    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    // ********************
    // operation select
    always_comb begin
        case (alu_op)
            ALU_ADD: begin
                result = op_a + op_b;
            end
            ALU_SUB: begin
                result = op_a - op_b;
            end
            ALU_AND: begin
                result = op_a & op_b;
            end
            ALU_OR: begin
                result = op_a | op_b;
            end
            ALU_XOR: begin
                result = op_a ^ op_b;
            end
            ALU_SLL: begin
                result = op_a << shamt;
            end
            ALU_SRL: begin
                result = op_a >> shamt;
            end
            ALU_SRA: begin
                result = xword_t'($signed(op_a) >>> shamt);
            end
            // set-less-than gives 0 or 1
            ALU_SLT: begin
                result = xword_t'(lt_signed);
            end
            ALU_SLTU: begin
                result = xword_t'(lt_unsigned);
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

//--- rtl/redirect_unit.sv
/*
 * branch resolution and redirect toward fetch
 * fetch sees one jump_flag pulse per instruction, even across stalls
 * jalr takes its base from the forwarded rs1 value
 */
module redirect_unit
    import exu_data_pkg::*;
    import exu_op_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ls_flush,
    input  logic       id_valid,
    input  logic       id_accept,
    input  logic       load_hazard,
    input  branch_op_e branch_op,
    input  xword_t     src1,
    input  xword_t     src2,
    input  pc_t        target_base,
    input  pc_t        target_offset,
    input  pc_t        id_next_pc,
    output logic       jump_flag,
    output pc_t        jump_addr,
    output pc_t        next_pc
);

    logic taken;
    logic jump_done;
    pc_t  base;
    pc_t  target_sum;

    // ********************
    // condition
    always_comb begin
        case (branch_op)
            BR_BEQ:  taken = src1 == src2;
            BR_BNE:  taken = src1 != src2;
            BR_BLT:  taken = $signed(src1) < $signed(src2);
            BR_BGE:  taken = $signed(src1) >= $signed(src2);
            BR_BLTU: taken = src1 < src2;
            BR_BGEU: taken = src1 >= src2;
            BR_JAL,
            BR_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // target
    assign base       = (branch_op == BR_JALR) ? src1 : target_base;
    assign target_sum = base + target_offset;
    assign jump_addr  = {target_sum[$bits(pc_t)-1:1], 1'b0};
    assign next_pc    = taken ? jump_addr : id_next_pc;

    // operands are only trusted once the load-use stall is gone
    assign jump_flag = id_valid && taken && !load_hazard && !jump_done;

    // set after the pulse, cleared when the instruction leaves
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            jump_done <= 1'b0;
        end else if (ls_flush || id_accept) begin
            jump_done <= 1'b0;
        end else if (jump_flag) begin
            jump_done <= 1'b1;
        end
    end

endmodule

//--- rtl/ex_ls_stage.sv
/*
 * issue control and the execute to load/store pipeline register
 * the register holds while load/store is not ready
 * flush drops the entry on the next edge
 */
module ex_ls_stage
    import exu_data_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ls_flush,
    input  logic     ls_ready,
    input  logic     id_valid,
    input  logic     load_hazard,
    output logic     id_ready,
    input  xword_t   alu_result,
    input  pc_t      next_pc,
    input  pc_t      id_pc,
    input  reg_idx_t id_rd,
    input  logic     id_dest_wen,
    input  logic     id_load,
    output logic     ex_valid,
    output logic     ex_dest_wen,
    output logic     ex_load,
    output reg_idx_t ex_rd,
    output xword_t   ex_result,
    output pc_t      ex_pc,
    output pc_t      ex_next_pc
);

    logic slot_free;

    // register is empty or drains this cycle
    assign slot_free = !ex_valid || ls_ready;

    // ********************
    // issue
    assign id_ready = id_valid && slot_free && !ls_flush && !load_hazard;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (ls_flush) begin
            ex_valid <= 1'b0;
        end else if (slot_free) begin
            ex_valid <= id_ready;
        end
    end

    // ********************
    // payload, only meaningful with ex_valid
    always_ff @(posedge clk) begin
        if (id_ready) begin
            ex_rd       <= id_rd;
            ex_dest_wen <= id_dest_wen;
            ex_load     <= id_load;
            ex_result   <= alu_result;
            ex_pc       <= id_pc;
            ex_next_pc  <= next_pc;
        end
    end

endmodule

//--- rtl/exu_top.sv
/*
 * integer execute stage of a five-stage pipeline, 64-bit data
 * one instruction per cycle, result registered toward load/store
 * no csr, multiply, divide, atomics or traps
 */
module exu_top
    import exu_data_pkg::*;
    import exu_op_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // decode
    input  logic       id_valid,
    output logic       id_ready,
    input  reg_idx_t   id_rs1,
    input  reg_idx_t   id_rs2,
    input  xword_t     id_operand1,
    input  xword_t     id_operand2,
    input  alu_op_e    id_alu_op,
    input  branch_op_e id_branch_op,
    input  pc_t        id_target_base,
    input  pc_t        id_target_offset,
    input  pc_t        id_pc,
    input  pc_t        id_next_pc,
    input  reg_idx_t   id_rd,
    input  logic       id_dest_wen,
    input  logic       id_load,
    // load/store
    input  logic       ls_ready,
    input  logic       ls_flush,
    output logic       ex_valid,
    output reg_idx_t   ex_rd,
    output logic       ex_dest_wen,
    output logic       ex_load,
    output xword_t     ex_result,
    output pc_t        ex_pc,
    output pc_t        ex_next_pc,
    // writeback
    input  logic       wb_valid,
    input  reg_idx_t   wb_rd,
    input  logic       wb_dest_wen,
    input  xword_t     wb_data,
    // fetch
    output logic       jump_flag,
    output pc_t        jump_addr
);

    xword_t src1;
    xword_t src2;
    xword_t alu_result;
    pc_t    next_pc;
    logic   load_hazard;
    logic   id_accept;

    assign id_accept = id_valid && id_ready;

    // ********************
    // operand forwarding
    operand_bypass bypass_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .ls_flush    (ls_flush),
        .id_valid    (id_valid),
        .id_accept   (id_accept),
        .id_rs1      (id_rs1),
        .id_rs2      (id_rs2),
        .id_operand1 (id_operand1),
        .id_operand2 (id_operand2),
        .ex_valid    (ex_valid),
        .ex_dest_wen (ex_dest_wen),
        .ex_load     (ex_load),
        .ex_rd       (ex_rd),
        .ex_result   (ex_result),
        .wb_valid    (wb_valid),
        .wb_dest_wen (wb_dest_wen),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .src1        (src1),
        .src2        (src2),
        .load_hazard (load_hazard)
    );

    // alu and branch work side by side on the same sources
    int_alu alu_i (
        .alu_op (id_alu_op),
        .op_a   (src1),
        .op_b   (src2),
        .result (alu_result)
    );

    redirect_unit redirect_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .ls_flush      (ls_flush),
        .id_valid      (id_valid),
        .id_accept     (id_accept),
        .load_hazard   (load_hazard),
        .branch_op     (id_branch_op),
        .src1          (src1),
        .src2          (src2),
        .target_base   (id_target_base),
        .target_offset (id_target_offset),
        .id_next_pc    (id_next_pc),
        .jump_flag     (jump_flag),
        .jump_addr     (jump_addr),
        .next_pc       (next_pc)
    );

    // ********************
    // pipeline register
    ex_ls_stage stage_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .ls_flush    (ls_flush),
        .ls_ready    (ls_ready),
        .id_valid    (id_valid),
        .load_hazard (load_hazard),
        .id_ready    (id_ready),
        .alu_result  (alu_result),
        .next_pc     (next_pc),
        .id_pc       (id_pc),
        .id_rd       (id_rd),
        .id_dest_wen (id_dest_wen),
        .id_load     (id_load),
        .ex_valid    (ex_valid),
        .ex_dest_wen (ex_dest_wen),
        .ex_load     (ex_load),
        .ex_rd       (ex_rd),
        .ex_result   (ex_result),
        .ex_pc       (ex_pc),
        .ex_next_pc  (ex_next_pc)
    );

endmodule

//--- dv/clk_gen.sv
/*
 * free running testbench clock and active low reset
 * reset is released on a rising edge after RESET_CYCLES edges
 */
module clk_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- dv/exu_tb.sv
/*
 * random test of the execute stage against a model of its rules
 * decode, load/store and writeback are emulated with fixed-seed traffic
 * register indices stay in 0..7 so forwarding and stalls happen often
 */
module exu_tb
    import exu_data_pkg::*;
    import exu_op_pkg::*;
();

    localparam int N_INSTR     = 2000;
    localparam int TIMEOUT_CYC = N_INSTR * 8;

    logic       clk;
    logic       rst_n;
    logic       id_valid, id_ready, id_dest_wen, id_load;
    reg_idx_t   id_rs1, id_rs2, id_rd;
    xword_t     id_operand1, id_operand2;
    alu_op_e    id_alu_op;
    branch_op_e id_branch_op;
    pc_t        id_target_base, id_target_offset, id_pc, id_next_pc;
    logic       ls_ready, ls_flush;
    logic       ex_valid, ex_dest_wen, ex_load;
    reg_idx_t   ex_rd;
    xword_t     ex_result;
    pc_t        ex_pc, ex_next_pc;
    logic       wb_valid, wb_dest_wen;
    reg_idx_t   wb_rd;
    xword_t     wb_data;
    logic       jump_flag;
    pc_t        jump_addr;

    // model of the ex/ls register, capture and jump state
    xword_t      rf [32];
    logic        m_valid, m_wen, m_load;
    reg_idx_t    m_rd;
    xword_t      m_result;
    pc_t         m_pc, m_next_pc;
    logic        cap_v [2];
    xword_t      cap_d [2];
    logic        jump_done;
    logic        accepted;
    int          n_accepted, n_jumps, n_stalls;
    logic [31:0] seed;

    clk_gen #(.PERIOD(40), .RESET_CYCLES(2)) clk_gen_i (.clk(clk), .rst_n(rst_n));

    exu_top dut_i (.*);

    function automatic logic [31:0] next_rand();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    // half the words are tiny, so compares hit equality and sign changes
    function automatic xword_t rand_word();
        xword_t w;
        w = {next_rand(), next_rand()};
        if (next_rand() % 2 == 0) begin
            w = {{62{w[1]}}, w[1:0]};
        end
        return w;
    endfunction

    // flipping the sign bit turns signed order into unsigned order
    function automatic logic signed_less(input xword_t a, input xword_t b);
        return {~a[63], a[62:0]} < {~b[63], b[62:0]};
    endfunction

    function automatic xword_t alu_expect(input alu_op_e op, input xword_t a, input xword_t b);
        logic [5:0] sh;
        xword_t     sign_fill;
        sh = b[5:0];
        sign_fill = a[63] ? ~({64{1'b1}} >> sh) : '0;
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 64'd1;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return (a >> sh) | sign_fill;
            ALU_SLT:  return {63'd0, signed_less(a, b)};
            ALU_SLTU: return {63'd0, a < b};
            default:  return '0;
        endcase
    endfunction

    function automatic logic branch_taken(input branch_op_e op, input xword_t a, input xword_t b);
        case (op)
            BR_BEQ:  return a == b;
            BR_BNE:  return a != b;
            BR_BLT:  return signed_less(a, b);
            BR_BGE:  return !signed_less(a, b);
            BR_BLTU: return a < b;
            BR_BGEU: return !(a < b);
            BR_JAL:  return 1'b1;
            BR_JALR: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic report_mismatch(input string msg);
        $display("[FAIL] t=%0t %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at the first mismatch");
    endtask

    // ********************
    // stimulus driven on the rising edge
    task automatic present_instr();
        reg_idx_t rs1;
        reg_idx_t rs2;
        pc_t      pc;
        rs1 = reg_idx_t'(next_rand() % 8);
        rs2 = (next_rand() % 4 == 0) ? '0 : reg_idx_t'(next_rand() % 8);
        pc  = {32'd0, next_rand() & 32'hffff_fffc};
        id_valid         <= 1'b1;
        id_rs1           <= rs1;
        id_rs2           <= rs2;
        // zero index slots carry an immediate or pc value
        id_operand1      <= (rs1 == '0) ? rand_word() : rf[rs1];
        id_operand2      <= (rs2 == '0) ? rand_word() : rf[rs2];
        id_alu_op        <= alu_op_e'(4'(next_rand() % 10));
        id_branch_op     <= (next_rand() % 2 == 0) ? BR_NONE
                                                   : branch_op_e'(4'(1 + next_rand() % 8));
        id_target_base   <= {next_rand(), next_rand()};
        id_target_offset <= {next_rand(), next_rand()};
        id_pc            <= pc;
        id_next_pc       <= pc + 64'd4;
        id_rd            <= reg_idx_t'(next_rand() % 8);
        id_dest_wen      <= (next_rand() % 8 != 0);
        id_load          <= (next_rand() % 4 == 0);
    endtask

    task automatic drive_traffic();
        ls_ready    <= (next_rand() % 4 != 0);
        ls_flush    <= (next_rand() % 64 == 0);
        wb_valid    <= (next_rand() % 3 != 0);
        wb_dest_wen <= (next_rand() % 5 != 0);
        wb_rd       <= reg_idx_t'(next_rand() % 8);
        wb_data     <= rand_word();
    endtask

    // ********************
    // checks on the falling edge
    task automatic check_ex_regs();
        assert (ex_valid === m_valid)
            else report_mismatch($sformatf("ex_valid %b, expected %b", ex_valid, m_valid));
        if (m_valid) begin
            assert (ex_result === m_result)
                else report_mismatch($sformatf("ex_result %h, expected %h", ex_result, m_result));
            assert (ex_rd === m_rd && ex_dest_wen === m_wen && ex_load === m_load)
                else report_mismatch($sformatf("ex_rd/wen/load %0d/%b/%b, expected %0d/%b/%b",
                                               ex_rd, ex_dest_wen, ex_load, m_rd, m_wen, m_load));
            assert (ex_pc === m_pc && ex_next_pc === m_next_pc)
                else report_mismatch($sformatf("ex_pc/next %h/%h, expected %h/%h",
                                               ex_pc, ex_next_pc, m_pc, m_next_pc));
        end
    endtask

    task automatic step_model();
        reg_idx_t rs [2];
        xword_t   src [2];
        logic     wb_w;
        logic     hazard;
        logic     exp_ready;
        logic     taken;
        logic     exp_jump;
        pc_t      target;
        rs[0]  = id_rs1;
        rs[1]  = id_rs2;
        src[0] = id_operand1;
        src[1] = id_operand2;
        wb_w   = wb_valid && wb_dest_wen;
        hazard = 1'b0;
        for (int i = 0; i < 2; i++) begin
            if (rs[i] != '0 && m_valid && m_wen && rs[i] == m_rd) begin
                src[i] = m_result;
                hazard = hazard || m_load;
            end else if (rs[i] != '0 && wb_w && rs[i] == wb_rd) begin
                src[i] = wb_data;
            end else if (cap_v[i]) begin
                src[i] = cap_d[i];
            end
        end
        exp_ready = id_valid && (!m_valid || ls_ready) && !ls_flush && !hazard;
        assert (id_ready === exp_ready)
            else report_mismatch($sformatf("id_ready %b, expected %b", id_ready, exp_ready));
        taken  = branch_taken(id_branch_op, src[0], src[1]);
        target = ((id_branch_op == BR_JALR) ? src[0] : id_target_base) + id_target_offset;
        target[0] = 1'b0;
        exp_jump  = id_valid && taken && !hazard && !jump_done;
        assert (jump_flag === exp_jump)
            else report_mismatch($sformatf("jump_flag %b, expected %b", jump_flag, exp_jump));
        if (exp_jump) begin
            assert (jump_addr === target)
                else report_mismatch($sformatf("jump_addr %h, expected %h", jump_addr, target));
            n_jumps++;
        end
        if (id_valid && hazard) begin
            n_stalls++;
        end
        accepted = id_valid && exp_ready;

        if (ls_flush) begin
            m_valid = 1'b0;
        end else if (!m_valid || ls_ready) begin
            m_valid = accepted;
        end
        if (accepted) begin
            m_rd      = id_rd;
            m_wen     = id_dest_wen;
            m_load    = id_load;
            m_result  = alu_expect(id_alu_op, src[0], src[1]);
            m_pc      = id_pc;
            m_next_pc = taken ? target : id_next_pc;
            n_accepted++;
        end
        // a writeback during a stall is kept until the instruction leaves
        for (int i = 0; i < 2; i++) begin
            if (ls_flush || accepted) begin
                cap_v[i] = 1'b0;
            end else if (id_valid && rs[i] != '0 && wb_w && rs[i] == wb_rd) begin
                cap_v[i] = 1'b1;
                cap_d[i] = wb_data;
            end
        end
        if (ls_flush || accepted) begin
            jump_done = 1'b0;
        end else if (exp_jump) begin
            jump_done = 1'b1;
        end
        if (wb_w && wb_rd != '0) begin
            rf[wb_rd] = wb_data;
        end
    endtask

    // ********************
    // main sequence
    initial begin
        seed             = 32'h26ddef14;
        id_valid         <= 1'b0;
        id_rs1           <= '0;
        id_rs2           <= '0;
        id_operand1      <= '0;
        id_operand2      <= '0;
        id_alu_op        <= ALU_ADD;
        id_branch_op     <= BR_NONE;
        id_target_base   <= '0;
        id_target_offset <= '0;
        id_pc            <= '0;
        id_next_pc       <= '0;
        id_rd            <= '0;
        id_dest_wen      <= 1'b0;
        id_load          <= 1'b0;
        ls_ready         <= 1'b1;
        ls_flush         <= 1'b0;
        wb_valid         <= 1'b0;
        wb_dest_wen      <= 1'b0;
        wb_rd            <= '0;
        wb_data          <= '0;
        m_valid    = 1'b0;
        cap_v[0]   = 1'b0;
        cap_v[1]   = 1'b0;
        jump_done  = 1'b0;
        accepted   = 1'b0;
        n_accepted = 0;
        n_jumps    = 0;
        n_stalls   = 0;
        for (int i = 0; i < 32; i++) begin
            rf[i] = (i == 0) ? '0 : rand_word();
        end

        @(posedge clk);
        @(negedge clk);
        assert (!ex_valid && !id_ready && !jump_flag)
            else report_mismatch("outputs not idle during reset");
        @(posedge rst_n);

        while (n_accepted < N_INSTR) begin
            @(posedge clk);
            drive_traffic();
            // decode holds an instruction until it is accepted
            if (accepted || !id_valid) begin
                if (next_rand() % 8 == 0) begin
                    id_valid <= 1'b0;
                end else begin
                    present_instr();
                end
            end
            @(negedge clk);
            check_ex_regs();
            step_model();
        end

        // last result still has to reach the ex/ls register
        @(posedge clk);
        id_valid <= 1'b0;
        @(negedge clk);
        check_ex_regs();
        $display("%0d instructions, %0d jumps, %0d load-use stall cycles",
                 n_accepted, n_jumps, n_stalls);
        $display("SIMULATION PASSED");
        $finish;
    end

    // watchdog
    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("timeout after %0d cycles, %0d of %0d instructions accepted",
                 TIMEOUT_CYC, n_accepted, N_INSTR);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- build.f
+incdir+rtl
rtl/exu_op_pkg.sv
rtl/exu_data_pkg.sv
rtl/operand_bypass.sv
rtl/int_alu.sv
rtl/redirect_unit.sv
rtl/ex_ls_stage.sv
rtl/exu_top.sv
dv/clk_gen.sv
dv/exu_tb.sv

//--- run.sh
#!/bin/sh
# builds the execute stage testbench with Verilator and runs it
# the exit status is nonzero when the build or the run fails
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module exu_tb -f build.f -o exu_sim &&
./obj_dir/exu_sim || { echo "execute stage simulation did not pass"; exit 1; }
